/* project.f */
hdl/fetch_pkg.sv
hdl/imem_loader.sv
hdl/instr_mem.sv
hdl/pc_unit.sv
hdl/instruction_fetch.sv
hdl/fetch_top.sv
bench/fetch_tb.sv

/* run_sim.sh */
#!/bin/sh
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f project.f \
    > "$LOG" 2>&1 &&
    ./obj_dir/Vfetch_tb >> "$LOG" 2>&1 ||
    echo "build or simulation stopped with an error" >> "$LOG"
cat "$LOG"
if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
grep -q "TB PASSED" "$LOG" || exit 1

/* bench/fetch_tb.sv */
module fetch_tb
    import fetch_pkg::*;
();

    localparam int INSTR_W       = DEF_INSTR_W;
    localparam int IMEM_DEPTH    = 16;
    localparam int FETCH_CREDITS = DEF_FETCH_CREDITS;
    localparam int ADDR_W        = $clog2(IMEM_DEPTH);
    localparam int NUM_STEPS     = 6;

    logic               i_clk;
    logic               i_rst;
    logic               i_load_valid;
    logic [ADDR_W-1:0]  i_load_addr;
    logic [INSTR_W-1:0] i_load_data;
    logic               i_load_last;
    logic               i_jump_valid;
    logic [INSTR_W-1:0] i_jump_target;
    logic               i_credit_return;
    logic               o_fetch_valid;
    logic [INSTR_W-1:0] o_fetch_instr;
    logic [INSTR_W-1:0] o_fetch_pc;
    logic [INSTR_W-1:0] o_fetch_pc_plus;
    logic               o_loading;

    logic [INSTR_W-1:0] prog_a [IMEM_DEPTH] = '{
        32'h0010_0093, 32'h0020_0113, 32'h0020_81b3, 32'h4011_8233,
        32'h0041_f2b3, 32'h0052_6333, 32'h0063_43b3, 32'h0073_1413,
        32'h0024_5493, 32'h0094_8533, 32'h00a5_05b3, 32'h00b5_8633,
        32'h00c6_06b3, 32'h00d6_8733, 32'h00e7_07b3, 32'hfe00_0ee3
    };
    logic [INSTR_W-1:0] prog_b [IMEM_DEPTH] = '{
        32'hb000_1001, 32'hb011_2002, 32'hb022_3003, 32'hb033_4004,
        32'hb044_5005, 32'hb055_6006, 32'hb066_7007, 32'hb077_8008,
        32'hb088_9009, 32'hb099_a00a, 32'hb0aa_b00b, 32'hb0bb_c00c,
        32'hb0cc_d00d, 32'hb0dd_e00e, 32'hb0ee_f00f, 32'hb0ff_0010
    };

    // prog 1 is program A and 2 is program B
    string step_name   [NUM_STEPS] = '{"reset_run", "load_a", "backpressure",
                                       "jump", "jump_wrap", "load_b"};
    int    step_prog   [NUM_STEPS] = '{0, 1, 0, 0, 0, 2};
    int    step_hold   [NUM_STEPS] = '{0, 0, 10, 0, 0, 0};     // cycles with credits withheld
    int    step_jump   [NUM_STEPS] = '{-1, -1, -1, 5, 3, -1};  // run cycle of the jump
    int    step_target [NUM_STEPS] = '{0, 0, 0, 11, 13, 0};
    int    step_run    [NUM_STEPS] = '{12, 24, 16, 16, 20, 24};

    logic [INSTR_W-1:0] mem_model [IMEM_DEPTH];
    load_state_t        m_state;
    int                 m_pc;
    int                 m_credits;
    logic               m_redirect;      // pc moved by jump or restart since last issue
    int                 m_redirect_pc;
    logic               exp_valid;
    logic               exp_redirect;
    int                 exp_redirect_pc;
    logic [INSTR_W-1:0] exp_instr;
    int                 exp_pc;
    int                 last_pc;
    int                 pending [$];     // cycle at which each queued word is consumed
    logic               withhold;
    int                 seed;
    int                 cycle_count;
    int                 cycle_limit;
    string              test_name;

    fetch_top #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) UUT (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_load_valid    (i_load_valid),
        .i_load_addr     (i_load_addr),
        .i_load_data     (i_load_data),
        .i_load_last     (i_load_last),
        .i_jump_valid    (i_jump_valid),
        .i_jump_target   (i_jump_target),
        .i_credit_return (i_credit_return),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_instr   (o_fetch_instr),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_pc_plus (o_fetch_pc_plus),
        .o_loading       (o_loading)
    );

    initial begin
        i_clk = 1'b0;
        forever begin
            #20 i_clk = ~i_clk;
        end
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            report_failure($sformatf("Fail %s %s: expected %0h, actual %0h",
                                     test_name, what, expected, actual));
        end
    endtask

    function automatic int table_cycles();
        int total;
        total = 0;
        for (int s = 0; s < NUM_STEPS; s++) begin
            total += step_hold[s] + step_run[s] + ((step_prog[s] != 0) ? IMEM_DEPTH : 0);
        end
        return total;
    endfunction

    // state right after reset
    task automatic model_reset();
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            mem_model[a] = '0;
        end
        m_state       = LOAD_IDLE;
        m_pc          = 0;
        m_credits     = FETCH_CREDITS;
        m_redirect    = 1'b1;
        m_redirect_pc = 0;
        exp_valid     = 1'b0;
        last_pc       = 0;
        pending.delete();
    endtask

    // one clock edge of the fetch stage with the inputs driven before it
    task automatic model_edge();
        logic issue;
        issue = (m_credits > 0) && (m_state == LOAD_IDLE);
        exp_valid = issue;
        if (issue) begin
            exp_pc          = m_pc;
            exp_instr       = mem_model[m_pc]; // write at this edge is not yet visible
            exp_redirect    = m_redirect;
            exp_redirect_pc = m_redirect_pc;
            m_redirect      = 1'b0;
        end
        if (issue && !i_credit_return) begin
            m_credits--;
        end else if (!issue && i_credit_return) begin
            m_credits++;
        end
        if (m_state == LOAD_RESTART) begin
            m_pc          = 0;
            m_redirect    = 1'b1;
            m_redirect_pc = 0;
        end else if (i_jump_valid) begin
            m_pc          = int'(i_jump_target);
            m_redirect    = 1'b1;
            m_redirect_pc = m_pc;
        end else if (issue) begin
            m_pc = (m_pc == IMEM_DEPTH - 1) ? 0 : m_pc + 1;
        end
        if (i_load_valid) begin
            mem_model[i_load_addr] = i_load_data;
        end
        if (i_load_valid && i_load_last) begin
            m_state = LOAD_RESTART;
        end else if (i_load_valid) begin
            m_state = LOAD_ACTIVE;
        end else if (m_state == LOAD_RESTART) begin
            m_state = LOAD_IDLE;
        end
    endtask

    task automatic check_outputs();
        check_value("loading", 32'(m_state == LOAD_ACTIVE), 32'(o_loading));
        check_value("valid", 32'(exp_valid), 32'(o_fetch_valid));
        if (exp_valid) begin
            if (exp_redirect) begin
                check_value("first pc after redirect", exp_redirect_pc, o_fetch_pc);
            end else begin
                check_value("pc step", (last_pc + 1) % IMEM_DEPTH, o_fetch_pc);
            end
            check_value("instr", exp_instr, o_fetch_instr);
            check_value("pc_plus", exp_pc + 1, o_fetch_pc_plus);
            last_pc = exp_pc;
        end
    endtask

    // decode queue pops each word after 0 to 3 cycles
    task automatic decode_model();
        int delay;
        if (o_fetch_valid) begin
            assert (pending.size() < FETCH_CREDITS) else begin
                report_failure("decode received more words than it had credits for");
            end
            delay = int'($unsigned($random(seed)) % 4);
            pending.push_back(cycle_count + delay);
        end
        i_credit_return = 1'b0;
        if (!withhold && pending.size() > 0 && pending[0] <= cycle_count) begin
            void'(pending.pop_front());
            i_credit_return = 1'b1;
        end
    endtask

    task automatic step_cycle();
        @(posedge i_clk);
        model_edge();
        @(negedge i_clk);
        check_outputs();
        decode_model();
        i_load_valid = 1'b0; // load and jump last one cycle unless driven again
        i_load_last  = 1'b0;
        i_jump_valid = 1'b0;
    endtask

    task automatic load_program(input int prog);
        for (int a = 0; a < IMEM_DEPTH; a++) begin
            i_load_valid = 1'b1;
            i_load_addr  = ADDR_W'(a);
            i_load_data  = (prog == 1) ? prog_a[a] : prog_b[a];
            i_load_last  = (a == IMEM_DEPTH - 1);
            step_cycle();
        end
    endtask

    task automatic run_step(input int s);
        test_name = step_name[s];
        if (step_prog[s] != 0) begin
            load_program(step_prog[s]);
        end
        withhold = 1'b1;
        for (int c = 0; c < step_hold[s]; c++) begin
            step_cycle();
            if (c > FETCH_CREDITS) begin // all credits are spent by now
                assert (!o_fetch_valid) else begin
                    report_failure("valid output while all credits were withheld");
                end
            end
        end
        withhold = 1'b0;
        for (int c = 0; c < step_run[s]; c++) begin
            if (c == step_jump[s]) begin
                i_jump_valid  = 1'b1;
                i_jump_target = INSTR_W'(step_target[s]);
            end
            step_cycle();
        end
    endtask

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            report_failure("timeout: the test steps did not finish in time");
        end
    end

    initial begin
        seed            = 74770;
        cycle_count     = 0;
        cycle_limit     = 2 * table_cycles() * 4;
        test_name       = "reset";
        withhold        = 1'b0;
        i_rst           = 1'b1;
        i_load_valid    = 1'b0;
        i_load_addr     = '0;
        i_load_data     = '0;
        i_load_last     = 1'b0;
        i_jump_valid    = 1'b0;
        i_jump_target   = '0;
        i_credit_return = 1'b0;
        model_reset();
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        check_value("valid in reset", 32'd0, 32'(o_fetch_valid));
        check_value("loading in reset", 32'd0, 32'(o_loading));
        i_rst = 1'b0;
        for (int s = 0; s < NUM_STEPS; s++) begin
            run_step(s);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

/* hdl/fetch_top.sv */
module fetch_top
    import fetch_pkg::*;
#(
    parameter int  INSTR_W       = DEF_INSTR_W,
    parameter int  IMEM_DEPTH    = DEF_IMEM_DEPTH,
    parameter int  FETCH_CREDITS = DEF_FETCH_CREDITS,
    localparam int ADDR_W        = $clog2(IMEM_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_load_valid,
    input  logic [ADDR_W-1:0]  i_load_addr,
    input  logic [INSTR_W-1:0] i_load_data,
    input  logic               i_load_last,
    input  logic               i_jump_valid,
    input  logic [INSTR_W-1:0] i_jump_target,
    input  logic               i_credit_return,
    output logic               o_fetch_valid,
    output logic [INSTR_W-1:0] o_fetch_instr,
    output logic [INSTR_W-1:0] o_fetch_pc,
    output logic [INSTR_W-1:0] o_fetch_pc_plus,
    output logic               o_loading
);

    logic               wr_en;
    logic [ADDR_W-1:0]  wr_addr;
    logic [INSTR_W-1:0] wr_data;
    logic               freeze;
    logic               restart;

    imem_loader #(
        .INSTR_W    (INSTR_W),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem_loader (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load_valid (i_load_valid),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .i_load_last  (i_load_last),
        .o_wr_en      (wr_en),
        .o_wr_addr    (wr_addr),
        .o_wr_data    (wr_data),
        .o_freeze     (freeze),
        .o_restart    (restart),
        .o_loading    (o_loading)
    );

    instruction_fetch #(
        .INSTR_W       (INSTR_W),
        .IMEM_DEPTH    (IMEM_DEPTH),
        .FETCH_CREDITS (FETCH_CREDITS)
    ) u_instruction_fetch (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_freeze        (freeze),
        .i_restart       (restart),
        .i_wr_en         (wr_en),
        .i_wr_addr       (wr_addr),
        .i_wr_data       (wr_data),
        .i_jump_valid    (i_jump_valid),
        .i_jump_target   (i_jump_target),
        .i_credit_return (i_credit_return),
        .o_fetch_valid   (o_fetch_valid),
        .o_fetch_instr   (o_fetch_instr),
        .o_fetch_pc      (o_fetch_pc),
        .o_fetch_pc_plus (o_fetch_pc_plus)
    );

endmodule

/* hdl/instruction_fetch.sv */
module instruction_fetch
    import fetch_pkg::*;
#(
    parameter int  INSTR_W       = DEF_INSTR_W,
    parameter int  IMEM_DEPTH    = DEF_IMEM_DEPTH,
    parameter int  FETCH_CREDITS = DEF_FETCH_CREDITS,
    localparam int ADDR_W        = $clog2(IMEM_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_freeze,
    input  logic               i_restart,
    input  logic               i_wr_en,
    input  logic [ADDR_W-1:0]  i_wr_addr,
    input  logic [INSTR_W-1:0] i_wr_data,
    input  logic               i_jump_valid,
    input  logic [INSTR_W-1:0] i_jump_target,
    input  logic               i_credit_return,
    output logic               o_fetch_valid,
    output logic [INSTR_W-1:0] o_fetch_instr,
    output logic [INSTR_W-1:0] o_fetch_pc,
    output logic [INSTR_W-1:0] o_fetch_pc_plus
);

    localparam int CRED_W = $clog2(FETCH_CREDITS + 1);
    localparam logic [CRED_W-1:0] MAX_CRED = CRED_W'(FETCH_CREDITS);

    logic [CRED_W-1:0]  credits;
    logic               issue;
    logic [INSTR_W-1:0] pc;
    logic [INSTR_W-1:0] pc_plus;
    logic               fetch_valid;
    logic [INSTR_W-1:0] fetch_pc;
    logic [INSTR_W-1:0] fetch_pc_plus;

    assign issue = (credits != '0) && !i_freeze;

    // one credit per issue, one back per decode pop
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            credits <= MAX_CRED;
        end else begin
            case ({issue, i_credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits; // both or neither
            endcase
        end
    end

    pc_unit #(
        .INSTR_W    (INSTR_W),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_pc_unit (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_advance     (issue),
        .i_restart     (i_restart),
        .i_jump_valid  (i_jump_valid),
        .i_jump_target (i_jump_target),
        .o_pc          (pc),
        .o_pc_plus     (pc_plus)
    );

    instr_mem #(
        .INSTR_W    (INSTR_W),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_instr_mem (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_en   (issue),
        .i_rd_addr (pc[ADDR_W-1:0]),
        .o_rd_data (o_fetch_instr)
    );

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= issue; // single-cycle pulse per read
        end
    end

    // pc pair captured alongside the memory read
    always_ff @(posedge i_clk) begin
        if (issue) begin
            fetch_pc      <= pc;
            fetch_pc_plus <= pc_plus;
        end
    end

    assign o_fetch_valid   = fetch_valid;
    assign o_fetch_pc      = fetch_pc;
    assign o_fetch_pc_plus = fetch_pc_plus;

    a_credits_bounded : assert property (
        @(posedge i_clk) disable iff (i_rst)
        credits <= MAX_CRED
    );

    // decode may only return what it was given
    a_no_return_when_full : assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_credit_return |-> (credits < MAX_CRED)
    );

endmodule

/* hdl/pc_unit.sv */
module pc_unit
    import fetch_pkg::*;
#(
    parameter int INSTR_W    = DEF_INSTR_W,
    parameter int IMEM_DEPTH = DEF_IMEM_DEPTH
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_advance,
    input  logic               i_restart,
    input  logic               i_jump_valid,
    input  logic [INSTR_W-1:0] i_jump_target,
    output logic [INSTR_W-1:0] o_pc,
    output logic [INSTR_W-1:0] o_pc_plus
);

    localparam logic [INSTR_W-1:0] LAST_PC = INSTR_W'(IMEM_DEPTH - 1);

    logic [INSTR_W-1:0] pc;
    logic [INSTR_W-1:0] pc_plus;
    logic [INSTR_W-1:0] pc_seq;
    pc_sel_t            pc_sel;

    assign pc_plus = pc + 1'b1;
    assign pc_seq  = (pc == LAST_PC) ? '0 : pc_plus; // wrap after last word

    assign pc_sel = i_jump_valid ? PC_JUMP : PC_SEQ;

    // restart beats jump, jump beats advance
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= '0;
        end else if (i_restart) begin
            pc <= '0;
        end else if (pc_sel == PC_JUMP) begin
            pc <= i_jump_target; // taken even without an issue
        end else if (i_advance) begin
            pc <= pc_seq;
        end
    end

    assign o_pc      = pc;
    assign o_pc_plus = pc_plus; // not wrapped, decode sees pc+1

    // jump target comes from outside the stage
    a_pc_in_range : assert property (
        @(posedge i_clk) disable iff (i_rst)
        o_pc < INSTR_W'(IMEM_DEPTH)
    );

endmodule

/* hdl/instr_mem.sv */
module instr_mem
    import fetch_pkg::*;
#(
    parameter int  INSTR_W    = DEF_INSTR_W,
    parameter int  IMEM_DEPTH = DEF_IMEM_DEPTH,
    localparam int ADDR_W     = $clog2(IMEM_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_wr_en,
    input  logic [ADDR_W-1:0]  i_wr_addr,
    input  logic [INSTR_W-1:0] i_wr_data,
    input  logic               i_rd_en,
    input  logic [ADDR_W-1:0]  i_rd_addr,
    output logic [INSTR_W-1:0] o_rd_data
);

    logic [INSTR_W-1:0] mem [IMEM_DEPTH];
    logic [INSTR_W-1:0] rd_data;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < IMEM_DEPTH; i++) begin
                mem[i] <= '0; // program area starts as all zeros
            end
        end else if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // read register keeps its value while no read is issued
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            rd_data <= mem[i_rd_addr];
        end
    end

    assign o_rd_data = rd_data;

endmodule

/* hdl/imem_loader.sv */
module imem_loader
    import fetch_pkg::*;
#(
    parameter int  INSTR_W    = DEF_INSTR_W,
    parameter int  IMEM_DEPTH = DEF_IMEM_DEPTH,
    localparam int ADDR_W     = $clog2(IMEM_DEPTH)
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_load_valid,
    input  logic [ADDR_W-1:0]  i_load_addr,
    input  logic [INSTR_W-1:0] i_load_data,
    input  logic               i_load_last,
    output logic               o_wr_en,
    output logic [ADDR_W-1:0]  o_wr_addr,
    output logic [INSTR_W-1:0] o_wr_data,
    output logic               o_freeze,
    output logic               o_restart,
    output logic               o_loading
);

    load_state_t state;
    load_state_t state_next;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= LOAD_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            LOAD_IDLE, LOAD_RESTART: begin
                if (i_load_valid && i_load_last) begin
                    state_next = LOAD_RESTART; // single-word load
                end else if (i_load_valid) begin
                    state_next = LOAD_ACTIVE;
                end else begin
                    state_next = LOAD_IDLE;
                end
            end
            LOAD_ACTIVE: begin
                if (i_load_valid && i_load_last) begin
                    state_next = LOAD_RESTART;
                end
            end
            default: begin
                state_next = LOAD_IDLE;
            end
        endcase
    end

    // memory takes one word per cycle, so host writes go straight through
    assign o_wr_en   = i_load_valid;
    assign o_wr_addr = i_load_addr;
    assign o_wr_data = i_load_data;

    assign o_loading = (state == LOAD_ACTIVE);
    assign o_freeze  = (state != LOAD_IDLE); // no issue during restart either
    assign o_restart = (state == LOAD_RESTART);

    a_last_needs_valid : assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_load_last |-> i_load_valid
    );

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

    localparam int DEF_INSTR_W       = 32; // instruction and pc width
    localparam int DEF_IMEM_DEPTH    = 64; // words of instruction storage
    localparam int DEF_FETCH_CREDITS = 4;  // decode queue depth, credits after reset

    // loader FSM, freeze is held outside LOAD_IDLE
    typedef enum logic [1:0] {
        LOAD_IDLE    = 2'b00, // fetch running normally
        LOAD_ACTIVE  = 2'b01, // host words arriving
        LOAD_RESTART = 2'b10  // one cycle, pc forced back to 0
    } load_state_t;

    typedef enum logic {
        PC_SEQ  = 1'b0, // pc+1 with wrap
        PC_JUMP = 1'b1  // target from a later stage
    } pc_sel_t;

endpackage
